// File: Makefile
# all of these can be set on the make command line
VERILATOR ?= verilator
TOP       ?= tb_eth_arb_mux
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
# 0 for fixed priority, 1 for round robin
ARB_TYPE  ?= 1
VFLAGS    ?= -Wno-fatal -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) \
		-GARB_TYPE=$(ARB_TYPE) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// File: arbiter.sv
// blocking request arbiter
`timescale 1ns/1ps
`default_nettype none

module arbiter #(
    parameter int                     S_COUNT  = 4,
    parameter eth_mux_pkg::arb_type_e ARB_TYPE = eth_mux_pkg::ARB_ROUND_ROBIN
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [S_COUNT-1:0]         request,
    input  wire logic [S_COUNT-1:0]         acknowledge,
    output logic      [S_COUNT-1:0]         grant,
    output logic                            grant_valid,
    output logic      [$clog2(S_COUNT)-1:0] grant_index
);

    localparam int IDX_W = $clog2(S_COUNT);

    logic [S_COUNT-1:0] grant_reg, grant_next;
    logic               grant_valid_reg, grant_valid_next;
    logic [IDX_W-1:0]   grant_index_reg, grant_index_next;
    // round robin mask of the bits above the last winner
    logic [S_COUNT-1:0] mask_reg, mask_next;

    logic [S_COUNT-1:0] masked_req;
    logic               use_mask;
    logic [IDX_W-1:0]   pick_index;
    logic               hold;

    // lowest set bit wins
    function automatic logic [IDX_W-1:0] low_index(input logic [S_COUNT-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = S_COUNT - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign grant       = grant_reg;
    assign grant_valid = grant_valid_reg;
    assign grant_index = grant_index_reg;

    assign masked_req = request & mask_reg;
    assign use_mask   = (ARB_TYPE == eth_mux_pkg::ARB_ROUND_ROBIN) && (masked_req != '0);
    assign pick_index = use_mask ? low_index(masked_req) : low_index(request);

    // grant is kept until its owner acknowledges
    assign hold = grant_valid_reg && ((grant_reg & acknowledge) == '0);

    always_comb begin
        grant_next       = grant_reg;
        grant_valid_next = grant_valid_reg;
        grant_index_next = grant_index_reg;
        mask_next        = mask_reg;

        if (hold) begin
            // nothing changes while a frame is in flight
        end else if (request != '0) begin
            grant_next       = S_COUNT'(1) << pick_index;
            grant_valid_next = 1'b1;
            grant_index_next = pick_index;
            // next search starts just above this winner
            mask_next        = ({S_COUNT{1'b1}} << pick_index) << 1;
        end else begin
            grant_next       = '0;
            grant_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_reg       <= '0;
            grant_valid_reg <= 1'b0;
            grant_index_reg <= '0;
            mask_reg        <= '1;
        end else begin
            grant_reg       <= grant_next;
            grant_valid_reg <= grant_valid_next;
            grant_index_reg <= grant_index_next;
            mask_reg        <= mask_next;
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant_reg) && (grant_valid_reg == (grant_reg != '0)));

endmodule

`default_nettype wire

// File: axis_out_reg.sv
// payload output register with skid entry
`timescale 1ns/1ps
`default_nettype none

module axis_out_reg (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    input  wire eth_mux_pkg::axis_beat_t in_beat,
    output logic                        in_ready,
    output logic                        m_axis_valid,
    output eth_mux_pkg::axis_beat_t     m_axis,
    input  wire logic                   m_axis_ready
);

    eth_mux_pkg::axis_beat_t out_beat_reg;
    eth_mux_pkg::axis_beat_t tmp_beat_reg;

    logic out_valid_reg, out_valid_next;
    logic tmp_valid_reg, tmp_valid_next;
    logic in_ready_reg;
    logic in_ready_early;

    logic store_in_to_out;
    logic store_in_to_tmp;
    logic store_tmp_to_out;

    assign in_ready     = in_ready_reg;
    assign m_axis_valid = out_valid_reg;
    assign m_axis       = out_beat_reg;

    // ready for next cycle if sink drains or both entries are empty
    assign in_ready_early = m_axis_ready || (!tmp_valid_reg && !out_valid_reg);

    always_comb begin
        out_valid_next   = out_valid_reg;
        tmp_valid_next   = tmp_valid_reg;
        store_in_to_out  = 1'b0;
        store_in_to_tmp  = 1'b0;
        store_tmp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (m_axis_ready || !out_valid_reg) begin
                // output free or draining
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // park the beat while the sink stalls
                tmp_valid_next  = in_valid;
                store_in_to_tmp = 1'b1;
            end
        end else if (m_axis_ready) begin
            out_valid_next   = tmp_valid_reg;
            tmp_valid_next   = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_reg <= 1'b0;
            tmp_valid_reg <= 1'b0;
            in_ready_reg  <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            tmp_valid_reg <= tmp_valid_next;
            in_ready_reg  <= in_ready_early;
        end
    end

    // beat storage
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat_reg <= in_beat;
        end else if (store_tmp_to_out) begin
            out_beat_reg <= tmp_beat_reg;
        end
        if (store_in_to_tmp) begin
            tmp_beat_reg <= in_beat;
        end
    end

    tmp_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        store_in_to_tmp |-> !tmp_valid_reg);

endmodule

`default_nettype wire

// File: eth_arb_mux.sv
// arbitrated ethernet frame mux
`timescale 1ns/1ps
`default_nettype none

module eth_arb_mux #(
    parameter int                     S_COUNT  = 4,
    parameter eth_mux_pkg::arb_type_e ARB_TYPE = eth_mux_pkg::ARB_ROUND_ROBIN
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,

    // source side
    input  wire logic [S_COUNT-1:0]                    s_hdr_valid,
    output logic      [S_COUNT-1:0]                    s_hdr_ready,
    input  wire eth_mux_pkg::eth_hdr_t [S_COUNT-1:0]   s_hdr,
    input  wire logic [S_COUNT-1:0]                    s_axis_valid,
    output logic      [S_COUNT-1:0]                    s_axis_ready,
    input  wire eth_mux_pkg::axis_beat_t [S_COUNT-1:0] s_axis,

    // sink side
    output logic                                       m_hdr_valid,
    input  wire logic                                  m_hdr_ready,
    output eth_mux_pkg::eth_hdr_t                      m_hdr,
    output logic                                       m_axis_valid,
    input  wire logic                                  m_axis_ready,
    output eth_mux_pkg::axis_beat_t                    m_axis
);

    localparam int IDX_W = $clog2(S_COUNT);

    eth_mux_pkg::frame_state_e state_reg, state_next;

    logic [S_COUNT-1:0] hdr_ready_reg, hdr_ready_next;
    logic               m_hdr_valid_reg, m_hdr_valid_next;
    eth_mux_pkg::eth_hdr_t m_hdr_reg;
    logic               load_hdr;

    // arbiter handshake
    logic [S_COUNT-1:0] request;
    logic [S_COUNT-1:0] acknowledge;
    logic [S_COUNT-1:0] grant;
    logic               grant_valid;
    logic [IDX_W-1:0]   grant_index;

    // granted payload
    eth_mux_pkg::axis_beat_t cur_beat;
    logic               cur_valid;
    logic               cur_xfer;
    logic               in_valid;
    logic               in_ready;

    assign s_hdr_ready = hdr_ready_reg;
    assign m_hdr_valid = m_hdr_valid_reg;
    assign m_hdr       = m_hdr_reg;

    arbiter #(
        .S_COUNT  (S_COUNT),
        .ARB_TYPE (ARB_TYPE)
    ) u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    // the granted source does not request again during its own frame
    assign request = s_hdr_valid & ~grant;

    assign cur_beat  = s_axis[grant_index];
    assign cur_valid = s_axis_valid[grant_index];

    // only the granted source sees payload ready
    assign s_axis_ready = S_COUNT'(in_ready && grant_valid) << grant_index;

    assign cur_xfer = cur_valid && in_ready && grant_valid;

    // release the grant on the last accepted beat
    assign acknowledge = grant & s_axis_valid & s_axis_ready & {S_COUNT{cur_beat.tlast}};

    assign in_valid = cur_valid && grant_valid;

    always_comb begin
        state_next       = state_reg;
        hdr_ready_next   = '0;
        m_hdr_valid_next = m_hdr_valid_reg && !m_hdr_ready;
        load_hdr         = 1'b0;

        // end of frame
        if (cur_xfer && cur_beat.tlast) begin
            state_next = eth_mux_pkg::ST_IDLE;
        end

        // start of frame once the header slot is free
        if (state_reg == eth_mux_pkg::ST_IDLE && grant_valid &&
            (m_hdr_ready || !m_hdr_valid_reg)) begin
            state_next       = eth_mux_pkg::ST_FRAME;
            hdr_ready_next   = grant;
            m_hdr_valid_next = 1'b1;
            load_hdr         = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_reg       <= eth_mux_pkg::ST_IDLE;
            hdr_ready_reg   <= '0;
            m_hdr_valid_reg <= 1'b0;
        end else begin
            state_reg       <= state_next;
            hdr_ready_reg   <= hdr_ready_next;
            m_hdr_valid_reg <= m_hdr_valid_next;
        end
    end

    // header capture
    always_ff @(posedge clk) begin
        if (load_hdr) begin
            m_hdr_reg <= s_hdr[grant_index];
        end
    end

    axis_out_reg u_out_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_beat      (cur_beat),
        .in_ready     (in_ready),
        .m_axis_valid (m_axis_valid),
        .m_axis       (m_axis),
        .m_axis_ready (m_axis_ready)
    );

    payload_ready_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (s_axis_ready & ~grant) == '0);

    // header ready only ever goes to the arbiter's winner
    hdr_ready_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (s_hdr_ready & ~grant) == '0);

endmodule

`default_nettype wire

// File: eth_mux_pkg.sv
// ethernet mux shared types
`default_nettype none

package eth_mux_pkg;

    // frame header as carried on the header channel
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one payload beat, byte wide
    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
        // frame error flag
        logic       tuser;
    } axis_beat_t;

    // arbitration mode
    typedef enum logic {
        ARB_PRIORITY,
        ARB_ROUND_ROBIN
    } arb_type_e;

    // header and frame tracking in the mux
    typedef enum logic {
        ST_IDLE,
        ST_FRAME
    } frame_state_e;

endpackage

`default_nettype wire

// File: tb_eth_arb_mux.sv
// eth arb mux testbench
`timescale 1ns/1ps
`default_nettype none

module tb_eth_arb_mux #(
    parameter int ARB_TYPE = 1
);

    localparam int S_COUNT = 4;
    // about 1500 cycles of traffic at most including stalls
    localparam int TIMEOUT_CYCLES = 4000;
    localparam eth_mux_pkg::arb_type_e ARB_MODE = eth_mux_pkg::arb_type_e'(ARB_TYPE);

    logic                                  clk = 1'b0;
    logic                                  rst_n = 1'b0;
    logic [S_COUNT-1:0]                    s_hdr_valid;
    logic [S_COUNT-1:0]                    s_hdr_ready;
    eth_mux_pkg::eth_hdr_t [S_COUNT-1:0]   s_hdr;
    logic [S_COUNT-1:0]                    s_axis_valid;
    logic [S_COUNT-1:0]                    s_axis_ready;
    eth_mux_pkg::axis_beat_t [S_COUNT-1:0] s_axis;
    logic                                  m_hdr_valid;
    logic                                  m_hdr_ready;
    eth_mux_pkg::eth_hdr_t                 m_hdr;
    logic                                  m_axis_valid;
    logic                                  m_axis_ready;
    eth_mux_pkg::axis_beat_t               m_axis;

    logic stall_en = 1'b0;
    int   seed = 32'h7551;
    int   cycle_count = 0;
    int   error_count = 0;
    int   pass_count = 0;
    int   fail_count = 0;
    // model round robin pointer so the first search starts at source 0
    int   last_winner = S_COUNT - 1;
    int   test_tag;
    int   frame_cnt [S_COUNT];
    int   frame_len [S_COUNT];
    bit   user_flag [S_COUNT];

    eth_mux_pkg::eth_hdr_t   hdr_q[$];
    eth_mux_pkg::eth_hdr_t   exp_hdr_q[$];
    eth_mux_pkg::axis_beat_t beat_q[$];
    eth_mux_pkg::axis_beat_t exp_beat_q[$];

    eth_arb_mux #(
        .S_COUNT  (S_COUNT),
        .ARB_TYPE (ARB_MODE)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .s_hdr        (s_hdr),
        .s_axis_valid (s_axis_valid),
        .s_axis_ready (s_axis_ready),
        .s_axis       (s_axis),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_hdr        (m_hdr),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .m_axis       (m_axis)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped, traffic not finished after %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // sink sets ready first so the transfer decision below is settled
    initial begin
        m_hdr_ready  = 1'b0;
        m_axis_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (stall_en) begin
                m_hdr_ready  = ($random(seed) & 3) != 0;
                m_axis_ready = ($random(seed) & 3) != 0;
            end else begin
                m_hdr_ready  = 1'b1;
                m_axis_ready = 1'b1;
            end
            if (m_hdr_valid && m_hdr_ready) begin
                hdr_q.push_back(m_hdr);
            end
            if (m_axis_valid && m_axis_ready) begin
                beat_q.push_back(m_axis);
            end
        end
    end

    function automatic eth_mux_pkg::eth_hdr_t make_hdr(input int src, input int tag);
        eth_mux_pkg::eth_hdr_t h;
        h.dest_mac = 48'h0200_5e00_0000 | 48'(src);
        h.src_mac  = 48'h0a00_0000_0000 | 48'(tag);
        h.eth_type = 16'h0800 + 16'(tag);
        return h;
    endfunction

    // source index sits in the top two data bits
    function automatic eth_mux_pkg::axis_beat_t make_beat(input int src, input int tag,
                                                         input int k, input int len,
                                                         input bit user);
        eth_mux_pkg::axis_beat_t b;
        b.tdata = {src[1:0], tag[2:0], k[2:0]};
        b.tlast = (k == len - 1);
        b.tuser = user && (k == len - 1);
        return b;
    endfunction

    task automatic run_source(input int src);
        int tag;
        for (int f = 0; f < frame_cnt[src]; f++) begin
            tag = test_tag + f;
            s_hdr[src]       = make_hdr(src, tag);
            s_hdr_valid[src] = 1'b1;
            while (!s_hdr_ready[src]) @(negedge clk);
            @(negedge clk);
            s_hdr_valid[src] = 1'b0;
            for (int k = 0; k < frame_len[src]; k++) begin
                s_axis[src]       = make_beat(src, tag, k, frame_len[src], user_flag[src]);
                s_axis_valid[src] = 1'b1;
                while (!s_axis_ready[src]) @(negedge clk);
                @(negedge clk);
            end
            s_axis_valid[src] = 1'b0;
        end
    endtask

    // expected frame order where the source that just finished asks again too late
    task automatic build_expected();
        int left [S_COUNT];
        int sent [S_COUNT];
        int prev;
        int pick;
        int s;
        int remaining;
        int tag;
        prev      = -1;
        remaining = 0;
        exp_hdr_q.delete();
        exp_beat_q.delete();
        for (int i = 0; i < S_COUNT; i++) begin
            left[i]   = frame_cnt[i];
            sent[i]   = 0;
            remaining += frame_cnt[i];
        end
        while (remaining > 0) begin
            pick = -1;
            for (int k = 1; k <= S_COUNT; k++) begin
                if (ARB_MODE == eth_mux_pkg::ARB_ROUND_ROBIN) begin
                    s = (last_winner + k) % S_COUNT;
                end else begin
                    s = k - 1;
                end
                if (pick < 0 && left[s] > 0 && s != prev) begin
                    pick = s;
                end
            end
            if (pick < 0) begin
                pick = prev;
            end
            tag = test_tag + sent[pick];
            exp_hdr_q.push_back(make_hdr(pick, tag));
            for (int k = 0; k < frame_len[pick]; k++) begin
                exp_beat_q.push_back(make_beat(pick, tag, k, frame_len[pick],
                                               user_flag[pick]));
            end
            left[pick]--;
            sent[pick]++;
            remaining--;
            prev        = pick;
            last_winner = pick;
        end
    endtask

    task automatic check_output();
        int nh;
        int nb;
        nh = exp_hdr_q.size();
        nb = exp_beat_q.size();
        while (hdr_q.size() < nh || beat_q.size() < nb) @(negedge clk);
        // room for anything duplicated to show up
        repeat (8) @(negedge clk);
        assert (hdr_q.size() == nh && beat_q.size() == nb) else begin
            $display("Mismatch at %0t: %0d headers and %0d beats, expected %0d and %0d",
                     $time, hdr_q.size(), beat_q.size(), nh, nb);
            error_count++;
        end
        for (int i = 0; i < nh && i < hdr_q.size(); i++) begin
            assert (hdr_q[i] == exp_hdr_q[i]) else begin
                $display("Mismatch at %0t: header %0d is %h, expected %h",
                         $time, i, hdr_q[i], exp_hdr_q[i]);
                error_count++;
            end
        end
        for (int i = 0; i < nb && i < beat_q.size(); i++) begin
            assert (beat_q[i] == exp_beat_q[i]) else begin
                $display("Mismatch at %0t: beat %0d data %h last %b user %b, expected %h %b %b",
                         $time, i, beat_q[i].tdata, beat_q[i].tlast, beat_q[i].tuser,
                         exp_beat_q[i].tdata, exp_beat_q[i].tlast, exp_beat_q[i].tuser);
                error_count++;
            end
        end
    endtask

    task automatic clear_setup(input int tag);
        test_tag = tag;
        for (int i = 0; i < S_COUNT; i++) begin
            frame_cnt[i] = 0;
            frame_len[i] = 0;
            user_flag[i] = 1'b0;
        end
    endtask

    task automatic run_traffic();
        hdr_q.delete();
        beat_q.delete();
        build_expected();
        @(negedge clk);
        fork
            run_source(0);
            run_source(1);
            run_source(2);
            run_source(3);
        join
        check_output();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("test %s passed at %0t", name, $time);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        assert (!m_hdr_valid && !m_axis_valid && s_hdr_ready == '0 &&
                s_axis_ready == '0) else begin
            $display("Mismatch at %0t: after reset valid %b %b hdr ready %b axis ready %b",
                     $time, m_hdr_valid, m_axis_valid, s_hdr_ready, s_axis_ready);
            error_count++;
        end
        finish_test("reset_state", errs);
    endtask

    task automatic test_single_frame();
        int errs;
        errs = error_count;
        clear_setup(1);
        frame_cnt[0] = 1;
        frame_len[0] = 5;
        run_traffic();
        finish_test("single_frame", errs);
    endtask

    // source 0 asks again right after its first frame
    task automatic test_arbitration_order();
        int errs;
        errs = error_count;
        clear_setup(2);
        for (int i = 0; i < S_COUNT; i++) begin
            frame_cnt[i] = 1;
            frame_len[i] = 4;
        end
        frame_cnt[0] = 2;
        run_traffic();
        finish_test("arbitration_order", errs);
    endtask

    task automatic test_no_interleave();
        int errs;
        int bi;
        int src;
        bit last;
        errs = error_count;
        clear_setup(3);
        for (int i = 1; i < S_COUNT; i++) begin
            frame_cnt[i] = 2;
            frame_len[i] = 5 + i;
        end
        run_traffic();
        bi = 0;
        for (int h = 0; h < hdr_q.size(); h++) begin
            src  = int'(hdr_q[h].dest_mac[1:0]);
            last = 1'b0;
            while (!last && bi < beat_q.size()) begin
                assert (int'(beat_q[bi].tdata[7:6]) == src) else begin
                    $display("Mismatch at %0t: beat %0d from source %0d inside frame of source %0d",
                             $time, bi, beat_q[bi].tdata[7:6], src);
                    error_count++;
                end
                last = beat_q[bi].tlast;
                bi++;
            end
        end
        finish_test("no_interleave", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = error_count;
        clear_setup(4);
        for (int i = 0; i < S_COUNT; i++) begin
            frame_cnt[i] = 3;
            frame_len[i] = 3 + ((i * 3) % 4);
        end
        stall_en = 1'b1;
        run_traffic();
        stall_en = 1'b0;
        finish_test("back_pressure", errs);
    endtask

    task automatic test_user_flag();
        int errs;
        errs = error_count;
        clear_setup(5);
        frame_cnt[2] = 1;
        frame_len[2] = 4;
        user_flag[2] = 1'b1;
        frame_cnt[3] = 1;
        frame_len[3] = 3;
        run_traffic();
        finish_test("user_flag", errs);
    endtask

    initial begin
        s_hdr_valid  = '0;
        s_hdr        = '0;
        s_axis_valid = '0;
        s_axis       = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_single_frame();
        test_arbitration_order();
        test_no_interleave();
        test_back_pressure();
        test_user_flag();

        $display("tests passed %0d failed %0d, %0d errors", pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
eth_mux_pkg.sv
arbiter.sv
axis_out_reg.sv
eth_arb_mux.sv
tb_eth_arb_mux.sv
